/* rtl/rs_pkg.sv */
// rs_issue shared definitions
// widths, depths, vector types and encodings used by the rename stage,
// the reservation station and the ALU

package rs_pkg;

    ////////////////////////////////////////////////////////////
    // widths and depths
    ////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int TAG_COUNT  = 8;
    localparam int RS_DEPTH   = 4;
    // issue edge to CDB for a multiply
    localparam int MUL_CYCLES = 4;

    // multiplier consumes one slice of operand b per cycle
    localparam int MUL_STEP   = XLEN / MUL_CYCLES;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]              data_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
    typedef logic [$clog2(TAG_COUNT)-1:0] tag_t;
    typedef logic [$clog2(RS_DEPTH)-1:0]  rs_idx_t;
    typedef logic [MUL_CNT_W-1:0]         mul_cnt_t;

    // ALU operations, loadi passes src1 through
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_MUL   = 3'd5,
        OP_LOADI = 3'd6
    } alu_op_t;

    // multiplier sequencer
    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_BUSY = 2'd1
    } mul_state_t;

endpackage

/* rtl/core_ifs.sv */
// rs_issue internal links
// dispatch, issue and common data bus connections between the stages

`timescale 1ns/1ps

// renamed instruction, rename stage to reservation station
interface dispatch_if;
    logic              valid;
    logic              ready;
    rs_pkg::alu_op_t   op;
    rs_pkg::tag_t      tag;
    logic              src1_ready;
    rs_pkg::tag_t      src1_tag;
    rs_pkg::data_t     src1_value;
    logic              src2_ready;
    rs_pkg::tag_t      src2_tag;
    rs_pkg::data_t     src2_value;

    modport producer (
        output valid, op, tag,
        output src1_ready, src1_tag, src1_value,
        output src2_ready, src2_tag, src2_value,
        input  ready
    );

    modport station (
        input  valid, op, tag,
        input  src1_ready, src1_tag, src1_value,
        input  src2_ready, src2_tag, src2_value,
        output ready
    );
endinterface

// operands ready to execute, station to ALU
interface issue_if;
    logic              valid;
    logic              ready;
    rs_pkg::alu_op_t   op;
    rs_pkg::tag_t      tag;
    rs_pkg::data_t     operand_a;
    rs_pkg::data_t     operand_b;

    modport station (output valid, op, tag, operand_a, operand_b, input ready);
    modport unit    (input valid, op, tag, operand_a, operand_b, output ready);
endinterface

// result broadcast, no back-pressure
interface cdb_if;
    logic              valid;
    rs_pkg::tag_t      tag;
    rs_pkg::data_t     value;

    modport source   (output valid, tag, value);
    modport listener (input valid, tag, value);
endinterface

/* rtl/rot_priority_select.sv */
// rotating priority selector
// grants one request searching upward from sel with wrap around,
// built as a tree of two-input cells

`timescale 1ns/1ps

module rot_priority_select #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0]         req,
    input  logic [$clog2(WIDTH)-1:0] sel,
    output logic [WIDTH-1:0]         gnt,
    output logic                     any
);

    assign any = |req;

    generate
        if (WIDTH == 2) begin : g_cell
            // leaf, sel picks which side goes first
            always_comb begin
                if (sel[0])
                    gnt = req[1] ? 2'b10 : {1'b0, req[0]};
                else
                    gnt = req[0] ? 2'b01 : {req[1], 1'b0};
            end
        end else begin : g_tree
            logic [WIDTH/2-1:0]         gnt_lo;
            logic [WIDTH/2-1:0]         gnt_hi;
            logic [WIDTH/2-1:0]         home_req;
            logic [$clog2(WIDTH)-2:0]   sub_sel;
            logic [$clog2(WIDTH)-2:0]   lo_sel;
            logic [$clog2(WIDTH)-2:0]   hi_sel;
            logic                       top;
            logic                       lo_any;
            logic                       hi_any;
            logic                       home_above;
            logic                       pick_hi;

            assign top     = sel[$clog2(WIDTH)-1];
            assign sub_sel = sel[$clog2(WIDTH)-2:0];
            // half holding sel starts at sel, other half from its bottom
            assign lo_sel  = top ? '0 : sub_sel;
            assign hi_sel  = top ? sub_sel : '0;

            rot_priority_select #(.WIDTH(WIDTH/2)) u_lo (
                .req(req[WIDTH/2-1:0]), .sel(lo_sel), .gnt(gnt_lo), .any(lo_any)
            );
            rot_priority_select #(.WIDTH(WIDTH/2)) u_hi (
                .req(req[WIDTH-1:WIDTH/2]), .sel(hi_sel), .gnt(gnt_hi), .any(hi_any)
            );

            // requests at or above sel inside the home half
            always_comb begin
                home_req   = top ? req[WIDTH-1:WIDTH/2] : req[WIDTH/2-1:0];
                home_above = 1'b0;
                for (int i = 0; i < WIDTH/2; i++) begin
                    if (home_req[i] && i >= int'(sub_sel))
                        home_above = 1'b1;
                end
            end

            // home above first, then other half, then home wrapped
            assign pick_hi = top ? (home_above || !lo_any) : (!home_above && hi_any);
            assign gnt     = pick_hi ? {gnt_hi, {(WIDTH/2){1'b0}}}
                                     : {{(WIDTH/2){1'b0}}, gnt_lo};
        end
    endgenerate

endmodule

/* rtl/rename_dispatch.sv */
// rename and dispatch stage
// register file with map table and a pool of result tags; reads both
// sources, bypasses a same-cycle CDB result and renames the destination

`timescale 1ns/1ps

module rename_dispatch (
    input  logic              clock,
    input  logic              rst,
    input  logic              inst_valid,
    input  rs_pkg::alu_op_t   inst_op,
    input  rs_pkg::reg_idx_t  inst_dest,
    input  rs_pkg::reg_idx_t  inst_src1,
    input  rs_pkg::reg_idx_t  inst_src2,
    input  rs_pkg::data_t     inst_imm,
    output logic              inst_ready,
    output rs_pkg::tag_t      inst_tag,
    dispatch_if.producer      disp,
    cdb_if.listener           cdb
);

    // architectural state plus map table
    rs_pkg::data_t                    reg_value [rs_pkg::REG_COUNT];
    logic [rs_pkg::REG_COUNT-1:0]     reg_ready;
    rs_pkg::tag_t                     reg_tag [rs_pkg::REG_COUNT];
    logic [rs_pkg::TAG_COUNT-1:0]     tag_busy;

    rs_pkg::tag_t                     free_tag;
    logic                             tag_avail;
    logic                             accept;

    rs_pkg::reg_idx_t                 src_idx [2];
    logic [1:0]                       src_rdy;
    rs_pkg::tag_t                     src_tag [2];
    rs_pkg::data_t                    src_val [2];

    ////////////////////////////////////////////////////////////
    // tag pool, lowest free tag first
    ////////////////////////////////////////////////////////////

    always_comb begin
        free_tag = '0;
        for (int i = rs_pkg::TAG_COUNT - 1; i >= 0; i--) begin
            if (!tag_busy[i])
                free_tag = rs_pkg::tag_t'(i);
        end
    end

    assign tag_avail  = ~&tag_busy;
    assign inst_ready = disp.ready && tag_avail;
    assign inst_tag   = free_tag;
    assign accept     = inst_valid && inst_ready;

    ////////////////////////////////////////////////////////////
    // operand read
    ////////////////////////////////////////////////////////////

    always_comb begin
        src_idx[0] = inst_src1;
        src_idx[1] = inst_src2;
        for (int s = 0; s < 2; s++) begin
            src_val[s] = reg_value[src_idx[s]];
            src_rdy[s] = reg_ready[src_idx[s]];
            src_tag[s] = reg_tag[src_idx[s]];
            // producer broadcasting right now
            if (!src_rdy[s] && cdb.valid && cdb.tag == src_tag[s]) begin
                src_val[s] = cdb.value;
                src_rdy[s] = 1'b1;
            end
        end
        // loadi carries the immediate, no register dependency
        if (inst_op == rs_pkg::OP_LOADI) begin
            src_val[0] = inst_imm;
            src_rdy[0] = 1'b1;
            src_val[1] = '0;
            src_rdy[1] = 1'b1;
        end
    end

    assign disp.valid      = inst_valid && tag_avail;
    assign disp.op         = inst_op;
    assign disp.tag        = free_tag;
    assign disp.src1_ready = src_rdy[0];
    assign disp.src1_tag   = src_tag[0];
    assign disp.src1_value = src_val[0];
    assign disp.src2_ready = src_rdy[1];
    assign disp.src2_tag   = src_tag[1];
    assign disp.src2_value = src_val[1];

    ////////////////////////////////////////////////////////////
    // register and map table update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < rs_pkg::REG_COUNT; r++) begin
                reg_value[r] <= '0;
                reg_ready[r] <= 1'b1;
                reg_tag[r]   <= '0;
            end
            tag_busy <= '0;
        end else begin
            if (cdb.valid) begin
                tag_busy[cdb.tag] <= 1'b0;
                // only the newest mapping still points at this tag
                for (int r = 0; r < rs_pkg::REG_COUNT; r++) begin
                    if (!reg_ready[r] && reg_tag[r] == cdb.tag) begin
                        reg_value[r] <= cdb.value;
                        reg_ready[r] <= 1'b1;
                    end
                end
            end
            // rename overrides a same-edge writeback to dest
            if (accept) begin
                tag_busy[free_tag]   <= 1'b1;
                reg_ready[inst_dest] <= 1'b0;
                reg_tag[inst_dest]   <= free_tag;
            end
        end
    end

endmodule

/* rtl/reservation_station.sv */
// reservation station
// holds renamed instructions until both operands arrive from dispatch or
// the CDB, then issues one ready entry per cycle in rotating order

`timescale 1ns/1ps

module reservation_station (
    input  logic          clock,
    input  logic          rst,
    dispatch_if.station   disp,
    issue_if.station      iss,
    cdb_if.listener       cdb
);

    // entry state
    logic [rs_pkg::RS_DEPTH-1:0]   busy;
    rs_pkg::alu_op_t               e_op [rs_pkg::RS_DEPTH];
    rs_pkg::tag_t                  e_tag [rs_pkg::RS_DEPTH];
    // per operand, index 0 is src1
    rs_pkg::data_t                 opnd_val [rs_pkg::RS_DEPTH][2];
    logic [1:0]                    opnd_rdy [rs_pkg::RS_DEPTH];
    rs_pkg::tag_t                  opnd_wait [rs_pkg::RS_DEPTH][2];

    logic [rs_pkg::RS_DEPTH-1:0]   entry_free;
    logic [rs_pkg::RS_DEPTH-1:0]   issue_req;
    logic [rs_pkg::RS_DEPTH-1:0]   issue_gnt;
    logic                          issue_any;
    rs_pkg::rs_idx_t               alloc_idx;
    rs_pkg::rs_idx_t               iss_idx;
    rs_pkg::rs_idx_t               rot_ptr;
    logic                          disp_fire;
    logic                          iss_fire;

    ////////////////////////////////////////////////////////////
    // issue selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++)
            issue_req[i] = busy[i] && (&opnd_rdy[i]);
    end

    rot_priority_select #(.WIDTH(rs_pkg::RS_DEPTH)) u_sel (
        .req (issue_req),
        .sel (rot_ptr),
        .gnt (issue_gnt),
        .any (issue_any)
    );

    // one-hot grant to entry index
    always_comb begin
        iss_idx = '0;
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            if (issue_gnt[i])
                iss_idx = rs_pkg::rs_idx_t'(i);
        end
    end

    assign iss.valid     = issue_any;
    assign iss.op        = e_op[iss_idx];
    assign iss.tag       = e_tag[iss_idx];
    assign iss.operand_a = opnd_val[iss_idx][0];
    assign iss.operand_b = opnd_val[iss_idx][1];
    assign iss_fire      = iss.valid && iss.ready;

    ////////////////////////////////////////////////////////////
    // allocation
    ////////////////////////////////////////////////////////////

    // an entry leaving on this edge counts as free
    always_comb begin
        alloc_idx = '0;
        for (int i = rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            entry_free[i] = !busy[i] || (iss_fire && issue_gnt[i]);
            if (entry_free[i])
                alloc_idx = rs_pkg::rs_idx_t'(i);
        end
    end

    assign disp.ready = |entry_free;
    assign disp_fire  = disp.valid && disp.ready;

    // busy flags and rotation pointer
    always_ff @(posedge clock) begin
        if (rst) begin
            busy    <= '0;
            rot_ptr <= '0;
        end else begin
            if (iss_fire) begin
                busy[iss_idx] <= 1'b0;
                rot_ptr       <= rs_pkg::rs_idx_t'(iss_idx + 1'b1);
            end
            // refill wins over the clear above
            if (disp_fire)
                busy[alloc_idx] <= 1'b1;
        end
    end

    // payload, CDB snoop then new entry write
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (cdb.valid && !opnd_rdy[i][s] && opnd_wait[i][s] == cdb.tag) begin
                    opnd_val[i][s] <= cdb.value;
                    opnd_rdy[i][s] <= 1'b1;
                end
            end
        end
        if (disp_fire) begin
            e_op[alloc_idx]         <= disp.op;
            e_tag[alloc_idx]        <= disp.tag;
            opnd_val[alloc_idx][0]  <= disp.src1_value;
            opnd_val[alloc_idx][1]  <= disp.src2_value;
            opnd_rdy[alloc_idx]     <= {disp.src2_ready, disp.src1_ready};
            opnd_wait[alloc_idx][0] <= disp.src1_tag;
            opnd_wait[alloc_idx][1] <= disp.src2_tag;
        end
    end

endmodule

/* rtl/alu_unit.sv */
// integer execution unit
// single-cycle logic and add ops plus an iterative multiplier, result
// registered onto the common data bus

`timescale 1ns/1ps

module alu_unit (
    input  logic      clock,
    input  logic      rst,
    issue_if.unit     iss,
    cdb_if.source     cdb
);

    rs_pkg::mul_state_t   mul_state;
    rs_pkg::mul_cnt_t     mul_count;
    rs_pkg::data_t        mul_acc;
    rs_pkg::data_t        mul_a;
    rs_pkg::data_t        mul_b;
    rs_pkg::data_t        mul_part;
    rs_pkg::tag_t         mul_tag;
    rs_pkg::data_t        simple_result;
    logic                 iss_fire;
    logic                 is_mul;
    logic                 mul_done;

    logic                 cdb_valid_q;
    rs_pkg::tag_t         cdb_tag_q;
    rs_pkg::data_t        cdb_value_q;

    // stall issue for the whole multiply
    assign iss.ready = (mul_state == rs_pkg::MUL_IDLE);
    assign iss_fire  = iss.valid && iss.ready;
    assign is_mul    = (iss.op == rs_pkg::OP_MUL);
    assign mul_done  = (mul_state == rs_pkg::MUL_BUSY) && (mul_count == rs_pkg::mul_cnt_t'(1));
    // next slice of b, low XLEN bits kept
    assign mul_part  = mul_a * mul_b[rs_pkg::MUL_STEP-1:0];

    always_comb begin
        case (iss.op)
            rs_pkg::OP_ADD:   simple_result = iss.operand_a + iss.operand_b;
            rs_pkg::OP_SUB:   simple_result = iss.operand_a - iss.operand_b;
            rs_pkg::OP_AND:   simple_result = iss.operand_a & iss.operand_b;
            rs_pkg::OP_OR:    simple_result = iss.operand_a | iss.operand_b;
            rs_pkg::OP_XOR:   simple_result = iss.operand_a ^ iss.operand_b;
            rs_pkg::OP_LOADI: simple_result = iss.operand_a;
            default:          simple_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // multiplier sequencer and CDB valid
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            mul_state   <= rs_pkg::MUL_IDLE;
            mul_count   <= '0;
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= 1'b0;
            case (mul_state)
                rs_pkg::MUL_IDLE: begin
                    if (iss_fire && is_mul) begin
                        mul_state <= rs_pkg::MUL_BUSY;
                        mul_count <= rs_pkg::mul_cnt_t'(rs_pkg::MUL_CYCLES - 1);
                    end else if (iss_fire) begin
                        cdb_valid_q <= 1'b1;
                    end
                end
                rs_pkg::MUL_BUSY: begin
                    mul_count <= mul_count - 1'b1;
                    if (mul_done) begin
                        cdb_valid_q <= 1'b1;
                        mul_state   <= rs_pkg::MUL_IDLE;
                    end
                end
                default: mul_state <= rs_pkg::MUL_IDLE;
            endcase
        end
    end

    // shift-add datapath and result register
    always_ff @(posedge clock) begin
        if (iss_fire && is_mul) begin
            mul_acc <= iss.operand_a * iss.operand_b[rs_pkg::MUL_STEP-1:0];
            mul_a   <= iss.operand_a << rs_pkg::MUL_STEP;
            mul_b   <= iss.operand_b >> rs_pkg::MUL_STEP;
            mul_tag <= iss.tag;
        end else if (mul_state == rs_pkg::MUL_BUSY) begin
            mul_acc <= mul_acc + mul_part;
            mul_a   <= mul_a << rs_pkg::MUL_STEP;
            mul_b   <= mul_b >> rs_pkg::MUL_STEP;
        end
        if (iss_fire && !is_mul) begin
            cdb_tag_q   <= iss.tag;
            cdb_value_q <= simple_result;
        end else if (mul_done) begin
            cdb_tag_q   <= mul_tag;
            cdb_value_q <= mul_acc + mul_part;
        end
    end

    assign cdb.valid = cdb_valid_q;
    assign cdb.tag   = cdb_tag_q;
    assign cdb.value = cdb_value_q;

endmodule

/* rtl/rs_issue_top.sv */
// rs_issue top level
// rename and dispatch, reservation station and ALU joined by the
// dispatch, issue and result buses

`timescale 1ns/1ps

module rs_issue_top (
    input  logic              clock,
    input  logic              rst,
    // instruction stream, program order
    input  logic              inst_valid,
    input  rs_pkg::alu_op_t   inst_op,
    input  rs_pkg::reg_idx_t  inst_dest,
    input  rs_pkg::reg_idx_t  inst_src1,
    input  rs_pkg::reg_idx_t  inst_src2,
    input  rs_pkg::data_t     inst_imm,
    output logic              inst_ready,
    output rs_pkg::tag_t      inst_tag,
    // result broadcast
    output logic              cdb_valid,
    output rs_pkg::tag_t      cdb_tag,
    output rs_pkg::data_t     cdb_value
);

    dispatch_if disp_bus ();
    issue_if    issue_bus ();
    cdb_if      cdb_bus ();

    rename_dispatch u_rename (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_op    (inst_op),
        .inst_dest  (inst_dest),
        .inst_src1  (inst_src1),
        .inst_src2  (inst_src2),
        .inst_imm   (inst_imm),
        .inst_ready (inst_ready),
        .inst_tag   (inst_tag),
        .disp       (disp_bus),
        .cdb        (cdb_bus)
    );

    reservation_station u_rs (
        .clock (clock),
        .rst   (rst),
        .disp  (disp_bus),
        .iss   (issue_bus),
        .cdb   (cdb_bus)
    );

    alu_unit u_alu (
        .clock (clock),
        .rst   (rst),
        .iss   (issue_bus),
        .cdb   (cdb_bus)
    );

    assign cdb_valid = cdb_bus.valid;
    assign cdb_tag   = cdb_bus.tag;
    assign cdb_value = cdb_bus.value;

endmodule

/* test/rs_ref_model.svh */
// in-order reference model for rs_issue
// architectural values in program order, expected result per tag and
// the set of tags still waiting for their broadcast

`ifndef RS_REF_MODEL_SVH
`define RS_REF_MODEL_SVH

// register values as a sequential machine sees them
rs_pkg::data_t                  model_regs [rs_pkg::REG_COUNT];
// result owed by each in-flight tag
rs_pkg::data_t                  exp_value [rs_pkg::TAG_COUNT];
logic [rs_pkg::TAG_COUNT-1:0]   pending;
int                             pending_count;

// all registers zero, nothing in flight
function automatic void model_reset();
    for (int r = 0; r < rs_pkg::REG_COUNT; r++)
        model_regs[r] = '0;
    for (int t = 0; t < rs_pkg::TAG_COUNT; t++)
        exp_value[t] = '0;
    pending       = '0;
    pending_count = 0;
endfunction

// result rule taken from the instruction definitions
function automatic rs_pkg::data_t op_result(
    input rs_pkg::alu_op_t op,
    input rs_pkg::data_t   a,
    input rs_pkg::data_t   b,
    input rs_pkg::data_t   imm
);
    rs_pkg::data_t r;
    case (op)
        rs_pkg::OP_ADD:   r = a + b;
        rs_pkg::OP_SUB:   r = a - b;
        rs_pkg::OP_AND:   r = a & b;
        rs_pkg::OP_OR:    r = a | b;
        rs_pkg::OP_XOR:   r = a ^ b;
        // 32-bit context keeps the low word of the product
        rs_pkg::OP_MUL:   r = a * b;
        rs_pkg::OP_LOADI: r = imm;
        default:          r = '0;
    endcase
    return r;
endfunction

// accepted instruction, update program-order state
function automatic void model_dispatch(
    input rs_pkg::alu_op_t  op,
    input rs_pkg::reg_idx_t dest,
    input rs_pkg::reg_idx_t src1,
    input rs_pkg::reg_idx_t src2,
    input rs_pkg::data_t    imm,
    input rs_pkg::tag_t     tag
);
    rs_pkg::data_t r;
    r                = op_result(op, model_regs[src1], model_regs[src2], imm);
    model_regs[dest] = r;
    exp_value[tag]   = r;
    pending[tag]     = 1'b1;
    pending_count++;
endfunction

// broadcast seen, tag no longer owed
function automatic void model_retire(input rs_pkg::tag_t tag);
    pending[tag] = 1'b0;
    pending_count--;
endfunction

`endif

/* test/rs_issue_tb.sv */
// testbench for rs_issue_top
// directed, random and back-pressure instruction streams, every CDB
// broadcast checked against an in-order register model

`timescale 1ns/1ps

module rs_issue_tb;

    localparam int STALL_LIMIT  = 200;
    localparam int DRAIN_LIMIT  = 2000;
    localparam int RANDOM_COUNT = 400;
    localparam int BURST_COUNT  = 12;

    logic              clock;
    logic              rst;
    logic              inst_valid;
    rs_pkg::alu_op_t   inst_op;
    rs_pkg::reg_idx_t  inst_dest;
    rs_pkg::reg_idx_t  inst_src1;
    rs_pkg::reg_idx_t  inst_src2;
    rs_pkg::data_t     inst_imm;
    logic              inst_ready;
    rs_pkg::tag_t      inst_tag;
    logic              cdb_valid;
    rs_pkg::tag_t      cdb_tag;
    rs_pkg::data_t     cdb_value;
    // inst_ready seen low with a request waiting
    logic              saw_stall;

    `include "rs_ref_model.svh"

    rs_issue_top UUT (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_op    (inst_op),
        .inst_dest  (inst_dest),
        .inst_src1  (inst_src1),
        .inst_src2  (inst_src2),
        .inst_imm   (inst_imm),
        .inst_ready (inst_ready),
        .inst_tag   (inst_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // drive one instruction, hold it until accepted
    task automatic send_inst(
        input rs_pkg::alu_op_t  op,
        input rs_pkg::reg_idx_t dest,
        input rs_pkg::reg_idx_t src1,
        input rs_pkg::reg_idx_t src2,
        input rs_pkg::data_t    imm
    );
        int waited;
        @(posedge clock);
        inst_valid <= 1'b1;
        inst_op    <= op;
        inst_dest  <= dest;
        inst_src1  <= src1;
        inst_src2  <= src2;
        inst_imm   <= imm;
        waited = 0;
        @(negedge clock);
        while (!inst_ready) begin
            waited++;
            if (waited > STALL_LIMIT)
                abort_run("instruction never accepted, inst_ready stayed low too long");
            @(negedge clock);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        inst_valid <= 1'b0;
        inst_imm   <= $urandom();
        @(negedge clock);
    endtask

    // small register set, dependencies are frequent
    function automatic rs_pkg::reg_idx_t pick_reg();
        return rs_pkg::reg_idx_t'($urandom_range(0, 3));
    endfunction

    task automatic random_phase(input int count);
        rs_pkg::alu_op_t op;
        for (int n = 0; n < count; n++) begin
            op = rs_pkg::alu_op_t'($urandom_range(0, 6));
            if ($urandom_range(0, 3) == 0)
                idle_cycle();
            else
                send_inst(op, pick_reg(), pick_reg(), pick_reg(), $urandom());
        end
    endtask

    // wait for every owed result, sampled at rising edges
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clock);
        while (pending_count != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT)
                abort_run($sformatf("drain timed out with %0d results outstanding",
                                    pending_count));
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checker, samples at the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!rst) begin
            if (inst_valid && !inst_ready)
                saw_stall = 1'b1;
            if (inst_valid && inst_ready) begin
                // a full tag pool must hold inst_ready low
                assert (pending_count < rs_pkg::TAG_COUNT)
                    else abort_run($sformatf("[FAIL] inst_ready: %h with %h pending, limit %h",
                                             inst_ready, pending_count, rs_pkg::TAG_COUNT));
                assert (!pending[inst_tag])
                    else abort_run($sformatf("[FAIL] inst_tag: %h reused while pending",
                                             inst_tag));
                model_dispatch(inst_op, inst_dest, inst_src1, inst_src2, inst_imm, inst_tag);
            end
            if (cdb_valid) begin
                assert (pending[cdb_tag])
                    else abort_run($sformatf("[FAIL] cdb_tag: %h broadcast while not pending",
                                             cdb_tag));
                assert (cdb_value == exp_value[cdb_tag])
                    else abort_run($sformatf("[FAIL] cdb_value: tag %h got %h expected %h",
                                             cdb_tag, cdb_value, exp_value[cdb_tag]));
                model_retire(cdb_tag);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h80ce744a));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_op    = rs_pkg::OP_ADD;
        inst_dest  = '0;
        inst_src1  = '0;
        inst_src2  = '0;
        inst_imm   = '0;
        saw_stall  = 1'b0;
        model_reset();
        repeat (3) @(posedge clock);
        rst <= 1'b0;

        // first cycle out of reset
        @(negedge clock);
        assert (!cdb_valid)
            else abort_run($sformatf("[FAIL] cdb_valid: %h after reset, expected 0", cdb_valid));
        assert (inst_ready)
            else abort_run($sformatf("[FAIL] inst_ready: %h after reset, expected 1", inst_ready));

        // every op once, raw chain through the CDB
        send_inst(rs_pkg::OP_LOADI, 1, 0, 0, 32'h1234_5678);
        send_inst(rs_pkg::OP_LOADI, 2, 0, 0, 32'h0000_0f0f);
        send_inst(rs_pkg::OP_ADD,   3, 1, 2, '0);
        send_inst(rs_pkg::OP_SUB,   4, 1, 2, '0);
        send_inst(rs_pkg::OP_AND,   5, 3, 2, '0);
        send_inst(rs_pkg::OP_OR,    6, 4, 5, '0);
        send_inst(rs_pkg::OP_XOR,   7, 6, 1, '0);
        send_inst(rs_pkg::OP_MUL,   8, 7, 2, '0);
        // waw pair on r9, reader must see the newer value
        send_inst(rs_pkg::OP_LOADI, 9, 0, 0, 32'haaaa_aaaa);
        send_inst(rs_pkg::OP_LOADI, 9, 0, 0, 32'h5555_0001);
        send_inst(rs_pkg::OP_ADD,  10, 9, 9, '0);
        send_inst(rs_pkg::OP_MUL,  11, 10, 8, '0);

        random_phase(RANDOM_COUNT);

        // dependent multiply burst fills the station
        send_inst(rs_pkg::OP_LOADI, 1, 0, 0, 32'd3);
        send_inst(rs_pkg::OP_LOADI, 2, 0, 0, 32'd5);
        saw_stall = 1'b0;
        for (int n = 0; n < BURST_COUNT; n++)
            send_inst(rs_pkg::OP_MUL, 1, 1, 2, '0);
        idle_cycle();
        @(posedge clock);
        assert (saw_stall)
            else abort_run("inst_ready never dropped during the multiply burst");

        random_phase(RANDOM_COUNT / 2);
        idle_cycle();
        drain();
        // quiet window, nothing more may appear on the CDB
        repeat (10) @(posedge clock);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* rs_issue.f */
+incdir+test
rtl/rs_pkg.sv
rtl/core_ifs.sv
rtl/rot_priority_select.sv
rtl/rename_dispatch.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/rs_issue_top.sv
test/rs_issue_tb.sv

/* Bender.yml */
package:
  name: rs_issue

sources:
  - files:
      - rtl/rs_pkg.sv
      - rtl/core_ifs.sv
      - rtl/rot_priority_select.sv
      - rtl/rename_dispatch.sv
      - rtl/reservation_station.sv
      - rtl/alu_unit.sv
      - rtl/rs_issue_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/rs_issue_tb.sv
